// ==== rtl/gcode_defines.svh ====
`ifndef GCODE_DEFINES_SVH
`define GCODE_DEFINES_SVH

// one ascii character
`define GCODE_BYTE_BITS 8
// value of one decimal digit
`define GCODE_DIGIT_BITS 4
// signed integer value of a word
`define GCODE_NUM_BITS 8
// signed value in hundredths
`define GCODE_PRECISE_BITS 16
// integer accumulator, leaves headroom to catch overflow
`define GCODE_WIDE_BITS 16

`endif

// ==== rtl/gcode_pkg.sv ====
`include "gcode_defines.svh"

package gcode_pkg;

	// classes of input characters
	typedef enum logic [2:0] {
		CC_DIGIT,
		CC_LETTER,
		CC_MINUS,
		CC_DOT,
		CC_SPACE,
		CC_NEWLINE,
		CC_OTHER
	} char_class_t;

	typedef struct packed {
		logic [`GCODE_BYTE_BITS-1:0] ch;
		char_class_t cls;
		logic [`GCODE_DIGIT_BITS-1:0] digit;
	} char_info_t;

	// letter is zero for a malformed word
	typedef struct packed {
		logic [`GCODE_BYTE_BITS-1:0] letter;
		logic too_big;
		logic signed [`GCODE_NUM_BITS-1:0] num;
		logic signed [`GCODE_PRECISE_BITS-1:0] precise;
	} word_t;

	typedef struct packed {
		logic present;
		logic too_big;
		logic signed [`GCODE_NUM_BITS-1:0] num;
		logic signed [`GCODE_PRECISE_BITS-1:0] precise;
	} arg_result_t;

	typedef struct packed {
		logic [`GCODE_BYTE_BITS-1:0] code_letter;
		logic signed [`GCODE_NUM_BITS-1:0] code_num;
		arg_result_t x;
		arg_result_t y;
		arg_result_t z;
		arg_result_t f;
		logic error;
	} gcode_cmd_t;

endpackage

// ==== rtl/char_decoder.sv ====
`timescale 1ns/1ps
`include "gcode_defines.svh"

module char_decoder import gcode_pkg::*; (
	input logic clk,
	input logic reset,
	input logic fetch,
	output logic char_req,
	input logic char_ack,
	input logic [`GCODE_BYTE_BITS-1:0] char_data,
	output logic char_valid,
	output char_info_t char_info
);

	typedef enum logic [1:0] {
		D_IDLE,
		D_ARM,
		D_REQ
	} dec_state_t;

	dec_state_t state;
	logic [`GCODE_BYTE_BITS-1:0] ch;
	char_class_t cls;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= D_IDLE;
			char_req <= 1'b0;
			char_valid <= 1'b0;
		end else begin
			char_valid <= 1'b0;
			case (state)
				D_IDLE: begin
					if (fetch && char_ack) begin
						state <= D_ARM;
					end else if (fetch) begin
						char_req <= 1'b1;
						state <= D_REQ;
					end
				end
				// previous handshake still closing
				D_ARM: begin
					if (!char_ack) begin
						char_req <= 1'b1;
						state <= D_REQ;
					end
				end
				D_REQ: begin
					if (char_ack) begin
						char_req <= 1'b0;
						char_valid <= 1'b1;
						state <= D_IDLE;
					end
				end
				default: state <= D_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == D_REQ && char_ack) begin
			ch <= char_data;
		end
	end

	always_comb begin
		case (ch) inside
			["0":"9"]: cls = CC_DIGIT;
			["A":"Z"]: cls = CC_LETTER;
			"-": cls = CC_MINUS;
			".": cls = CC_DOT;
			// tab and carriage return act as blanks
			" ", 8'h09, 8'h0d: cls = CC_SPACE;
			8'h0a: cls = CC_NEWLINE;
			default: cls = CC_OTHER;
		endcase
	end

	assign char_info = '{
		ch: ch,
		cls: cls,
		digit: (cls == CC_DIGIT) ? ch[`GCODE_DIGIT_BITS-1:0] : '0
	};

	// a new request waits for the source to release ack
	a_req_after_ack: assert property (@(posedge clk) disable iff (reset)
		char_ack && !char_req |=> !char_req);

endmodule

// ==== rtl/number_builder.sv ====
`timescale 1ns/1ps
`include "gcode_defines.svh"

module number_builder #(
	parameter int NUM_BITS = `GCODE_WIDE_BITS
) (
	input logic clk,
	input logic reset,
	input logic zero,
	input logic advance,
	input logic is_negative,
	input logic [`GCODE_DIGIT_BITS-1:0] digit,
	output logic signed [NUM_BITS-1:0] num
);

	localparam logic signed [NUM_BITS-1:0] TEN = 10;

	logic signed [NUM_BITS-1:0] digit_ext;
	logic signed [NUM_BITS-1:0] scaled;
	logic signed [NUM_BITS-1:0] next_num;

	assign digit_ext = NUM_BITS'(digit);
	assign scaled = num * TEN;

	// negative values grow downward so the sign never needs a flip
	assign next_num = is_negative ? scaled - digit_ext : scaled + digit_ext;

	always_ff @(posedge clk) begin
		if (reset || zero) begin
			num <= '0;
		end else if (advance) begin
			num <= next_num;
		end
	end

endmodule

// ==== rtl/arg_subparser.sv ====
`timescale 1ns/1ps
`include "gcode_defines.svh"

module arg_subparser import gcode_pkg::*; (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic char_valid,
	input char_info_t char_info,
	output logic fetch,
	output logic word_valid,
	output word_t word,
	output logic line_end
);

	localparam int NUM_MAX = (1 << (`GCODE_NUM_BITS - 1)) - 1;
	localparam int NUM_MIN = -(1 << (`GCODE_NUM_BITS - 1));
	localparam logic signed [`GCODE_PRECISE_BITS-1:0] TEN = 10;
	localparam logic signed [`GCODE_PRECISE_BITS-1:0] HUNDRED = 100;

	typedef enum logic [2:0] {
		S_LETTER,
		S_SIGN,
		S_INT,
		S_FRAC,
		S_TERM
	} sub_state_t;

	sub_state_t state;
	logic pending;
	logic negative;
	logic seen_digit;
	logic bad;
	logic too_big;
	logic [1:0] frac_cnt;
	logic [`GCODE_BYTE_BITS-1:0] letter;
	logic is_digit;
	logic is_term;
	logic emit;
	logic adv_int;
	logic adv_precise;
	logic out_of_range;
	logic word_bad;
	logic word_big;
	logic signed [`GCODE_WIDE_BITS-1:0] wide_num;
	logic signed [`GCODE_PRECISE_BITS-1:0] precise_num;
	logic signed [`GCODE_PRECISE_BITS-1:0] precise_pad;

	number_builder #(
		.NUM_BITS(`GCODE_WIDE_BITS)
	) u_int_builder (
		.clk(clk),
		.reset(reset),
		.zero(emit),
		.advance(adv_int),
		.is_negative(negative),
		.digit(char_info.digit),
		.num(wide_num)
	);

	number_builder #(
		.NUM_BITS(`GCODE_PRECISE_BITS)
	) u_precise_builder (
		.clk(clk),
		.reset(reset),
		.zero(emit),
		.advance(adv_precise),
		.is_negative(negative),
		.digit(char_info.digit),
		.num(precise_num)
	);

	// no fetch while a word or a finished line is on its way out
	assign fetch = !pending && !busy && !word_valid;

	assign is_digit = char_info.cls == CC_DIGIT;
	assign is_term = char_info.cls == CC_SPACE || char_info.cls == CC_NEWLINE;
	assign emit = char_valid && is_term
		&& (state != S_LETTER || char_info.cls == CC_NEWLINE);
	assign adv_int = char_valid && is_digit && (state == S_SIGN || state == S_INT);
	assign adv_precise = adv_int || (char_valid && is_digit && state == S_FRAC);

	assign out_of_range = int'(wide_num) > NUM_MAX || int'(wide_num) < NUM_MIN;
	assign word_bad = bad || !seen_digit;
	assign word_big = too_big || out_of_range;

	// missing fraction digits count as trailing zeros
	always_comb begin
		case (frac_cnt)
			2'd0: precise_pad = precise_num * HUNDRED;
			2'd1: precise_pad = precise_num * TEN;
			default: precise_pad = precise_num;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_LETTER;
			pending <= 1'b0;
			negative <= 1'b0;
			seen_digit <= 1'b0;
			bad <= 1'b0;
			too_big <= 1'b0;
			frac_cnt <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			if (fetch) begin
				pending <= 1'b1;
			end else if (char_valid) begin
				pending <= 1'b0;
			end
			// sticky so later digits cannot wrap the accumulator back in range
			if (out_of_range) begin
				too_big <= 1'b1;
			end
			if (emit) begin
				word_valid <= 1'b1;
				state <= S_LETTER;
				negative <= 1'b0;
				seen_digit <= 1'b0;
				bad <= 1'b0;
				too_big <= 1'b0;
				frac_cnt <= '0;
			end else if (char_valid) begin
				case (state)
					S_LETTER: begin
						if (char_info.cls == CC_LETTER) begin
							state <= S_SIGN;
						end else if (char_info.cls != CC_SPACE) begin
							bad <= 1'b1;
							state <= S_TERM;
						end
					end
					S_SIGN: begin
						if (char_info.cls == CC_MINUS) begin
							negative <= 1'b1;
							state <= S_INT;
						end else if (is_digit) begin
							seen_digit <= 1'b1;
							state <= S_INT;
						end else begin
							bad <= 1'b1;
							state <= S_TERM;
						end
					end
					S_INT: begin
						if (is_digit) begin
							seen_digit <= 1'b1;
						end else if (char_info.cls == CC_DOT) begin
							state <= S_FRAC;
						end else begin
							bad <= 1'b1;
							state <= S_TERM;
						end
					end
					S_FRAC: begin
						if (is_digit) begin
							frac_cnt <= frac_cnt + 2'd1;
							if (frac_cnt == 2'd1) begin
								state <= S_TERM;
							end
						end else begin
							bad <= 1'b1;
							state <= S_TERM;
						end
					end
					// digits past the second fraction digit are dropped
					S_TERM: begin
						if (!is_digit) begin
							bad <= 1'b1;
						end
					end
					default: state <= S_LETTER;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (char_valid && state == S_LETTER && char_info.cls == CC_LETTER) begin
			letter <= char_info.ch;
		end
		if (emit) begin
			line_end <= char_info.cls == CC_NEWLINE;
			word.letter <= word_bad ? '0 : letter;
			word.too_big <= word_big;
			word.num <= (word_bad || word_big) ? '0 : wide_num[`GCODE_NUM_BITS-1:0];
			word.precise <= (word_bad || word_big) ? '0 : precise_pad;
		end
	end

	a_word_pulse: assert property (@(posedge clk) disable iff (reset)
		word_valid |=> !word_valid);

endmodule

// ==== rtl/command_assembler.sv ====
`timescale 1ns/1ps

module command_assembler import gcode_pkg::*; (
	input logic clk,
	input logic reset,
	input logic word_valid,
	input word_t word,
	input logic line_end,
	output logic busy,
	output logic cmd_req,
	input logic cmd_ack,
	output gcode_cmd_t cmd
);

	arg_result_t slot;

	assign slot = '{
		present: 1'b1,
		too_big: word.too_big,
		num: word.num,
		precise: word.precise
	};

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_req <= 1'b0;
			busy <= 1'b0;
			cmd <= '0;
		end else if (cmd_req) begin
			if (cmd_ack) begin
				cmd_req <= 1'b0;
				cmd <= '0;
			end
		end else if (busy) begin
			// sink has to drop ack before the next line may start
			if (!cmd_ack) begin
				busy <= 1'b0;
			end
		end else if (word_valid) begin
			case (word.letter)
				"G", "M": begin
					cmd.code_letter <= word.letter;
					cmd.code_num <= word.num;
				end
				"X": cmd.x <= slot;
				"Y": cmd.y <= slot;
				"Z": cmd.z <= slot;
				"F": cmd.f <= slot;
				// unknown letter or malformed word
				default: cmd.error <= 1'b1;
			endcase
			if (line_end) begin
				cmd_req <= 1'b1;
				busy <= 1'b1;
			end
		end
	end

	a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
		cmd_req && !cmd_ack |=> $stable(cmd));

endmodule

// ==== rtl/gcode_parser.sv ====
`timescale 1ns/1ps
`include "gcode_defines.svh"

module gcode_parser import gcode_pkg::*; (
	input logic clk,
	input logic reset,
	output logic char_req,
	input logic char_ack,
	input logic [`GCODE_BYTE_BITS-1:0] char_data,
	output logic cmd_req,
	input logic cmd_ack,
	output gcode_cmd_t cmd
);

	logic fetch;
	logic char_valid;
	char_info_t char_info;
	logic word_valid;
	word_t word;
	logic line_end;
	logic busy;

	char_decoder u_decoder (
		.clk(clk),
		.reset(reset),
		.fetch(fetch),
		.char_req(char_req),
		.char_ack(char_ack),
		.char_data(char_data),
		.char_valid(char_valid),
		.char_info(char_info)
	);

	arg_subparser u_subparser (
		.clk(clk),
		.reset(reset),
		.busy(busy),
		.char_valid(char_valid),
		.char_info(char_info),
		.fetch(fetch),
		.word_valid(word_valid),
		.word(word),
		.line_end(line_end)
	);

	// holds busy while a finished line waits for the sink
	command_assembler u_assembler (
		.clk(clk),
		.reset(reset),
		.word_valid(word_valid),
		.word(word),
		.line_end(line_end),
		.busy(busy),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.cmd(cmd)
	);

endmodule

// ==== sim/tb_gcode_parser.sv ====
`timescale 1ns/1ps
`include "gcode_defines.svh"

module tb_gcode_parser import gcode_pkg::*; ();

	localparam int WAIT_LIMIT = 2000;

	logic clk;
	logic reset;
	logic char_req;
	logic char_ack;
	logic [`GCODE_BYTE_BITS-1:0] char_data;
	logic cmd_req;
	logic cmd_ack;
	gcode_cmd_t cmd;

	gcode_cmd_t exp_q[$];
	gcode_cmd_t got_q[$];
	int sent;
	int checked;
	int errors;
	int err_mark;
	int passed;
	int failed;
	int src_max;
	int sink_max;
	bit hung;

	gcode_parser dut (
		.clk(clk),
		.reset(reset),
		.char_req(char_req),
		.char_ack(char_ack),
		.char_data(char_data),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.cmd(cmd)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// value of one word from its text with letter zero when malformed
	function automatic word_t eval_word(input string tok);
		word_t w;
		int k;
		int mag;
		int frac;
		int nfrac;
		int ndig;
		int value;
		int whole;
		bit neg;
		bit dot;
		bit ok;
		w = '0;
		mag = 0;
		frac = 0;
		nfrac = 0;
		ndig = 0;
		neg = 1'b0;
		dot = 1'b0;
		ok = tok[0] >= "A" && tok[0] <= "Z";
		k = 1;
		if (k < tok.len() && tok[k] == "-") begin
			neg = 1'b1;
			k++;
		end
		while (k < tok.len()) begin
			if (tok[k] >= "0" && tok[k] <= "9") begin
				if (!dot) begin
					mag = mag * 10 + (int'(tok[k]) - 48);
					ndig++;
				end else if (nfrac < 2) begin
					frac = frac * 10 + (int'(tok[k]) - 48);
					nfrac++;
				end
			end else if (tok[k] == "." && !dot && ndig > 0) begin
				dot = 1'b1;
			end else begin
				ok = 1'b0;
			end
			k++;
		end
		if (!ok || ndig == 0) begin
			return w;
		end
		w.letter = tok[0];
		w.too_big = neg ? mag > 128 : mag > 127;
		if (!w.too_big) begin
			value = mag * 100 + (nfrac == 2 ? frac : (nfrac == 1 ? frac * 10 : 0));
			value = neg ? -value : value;
			whole = neg ? -mag : mag;
			w.num = whole[`GCODE_NUM_BITS-1:0];
			w.precise = value[`GCODE_PRECISE_BITS-1:0];
		end
		return w;
	endfunction

	function automatic gcode_cmd_t file_word(input gcode_cmd_t c, input word_t w);
		gcode_cmd_t r;
		arg_result_t a;
		r = c;
		a = '{present: 1'b1, too_big: w.too_big, num: w.num, precise: w.precise};
		case (w.letter)
			"G", "M": begin
				r.code_letter = w.letter;
				r.code_num = w.num;
			end
			"X": r.x = a;
			"Y": r.y = a;
			"Z": r.z = a;
			"F": r.f = a;
			default: r.error = 1'b1;
		endcase
		return r;
	endfunction

	// expected command for one line without its newline
	function automatic gcode_cmd_t parse_line(input string line);
		gcode_cmd_t c;
		int i;
		int start;
		c = '0;
		start = 0;
		for (i = 0; i <= line.len(); i++) begin
			if (i == line.len() || line[i] == " ") begin
				if (i > start) begin
					c = file_word(c, eval_word(line.substr(start, i - 1)));
				end
				start = i + 1;
			end
		end
		// newline after a blank or on an empty line closes an empty word
		if (line.len() == 0 || line[line.len() - 1] == " ") begin
			c.error = 1'b1;
		end
		return c;
	endfunction

	function automatic string random_line();
		string s;
		string letters;
		int n;
		int k;
		int j;
		int idx;
		int nfrac;
		letters = "XYZF";
		if ($urandom % 2 == 0) begin
			s = $sformatf("G%0d", $urandom % 4);
		end else begin
			s = $sformatf("M%0d", $urandom % 10);
		end
		n = $urandom % 5;
		for (k = 0; k < n; k++) begin
			idx = $urandom % 4;
			s = {s, " ", letters.substr(idx, idx)};
			if ($urandom % 2 == 0) begin
				s = {s, "-"};
			end
			s = {s, $sformatf("%0d", $urandom % 200)};
			nfrac = $urandom % 4;
			if (nfrac > 0) begin
				s = {s, "."};
			end
			for (j = 0; j < nfrac; j++) begin
				s = {s, $sformatf("%0d", $urandom % 10)};
			end
		end
		return s;
	endfunction

	task automatic check_field(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_arg(input string name, input arg_result_t got, input arg_result_t exp);
		check_field({name, ".present"}, int'(got.present), int'(exp.present));
		check_field({name, ".too_big"}, int'(got.too_big), int'(exp.too_big));
		check_field({name, ".num"}, int'(got.num), int'(exp.num));
		check_field({name, ".precise"}, int'(got.precise), int'(exp.precise));
	endtask

	task automatic compare_cmd(input gcode_cmd_t got, input gcode_cmd_t exp);
		check_field("cmd.code_letter", int'(got.code_letter), int'(exp.code_letter));
		check_field("cmd.code_num", int'(got.code_num), int'(exp.code_num));
		check_field("cmd.error", int'(got.error), int'(exp.error));
		compare_arg("cmd.x", got.x, exp.x);
		compare_arg("cmd.y", got.y, exp.y);
		compare_arg("cmd.z", got.z, exp.z);
		compare_arg("cmd.f", got.f, exp.f);
	endtask

	// one four-phase character transfer
	task automatic send_char(input logic [`GCODE_BYTE_BITS-1:0] c);
		int t;
		int delay;
		t = 0;
		while (!char_req && !hung) begin
			@(negedge clk);
			t++;
			if (t > WAIT_LIMIT) begin
				$display("timeout: the DUT stopped requesting characters");
				hung = 1'b1;
				errors++;
			end
		end
		delay = $urandom % (src_max + 1);
		repeat (delay) @(negedge clk);
		char_data = c;
		char_ack = 1'b1;
		t = 0;
		while (char_req && !hung) begin
			@(negedge clk);
			t++;
			if (t > WAIT_LIMIT) begin
				$display("timeout: the DUT never released char_req");
				hung = 1'b1;
				errors++;
			end
		end
		// a slow source may keep ack up after the request is gone
		delay = $urandom % (src_max + 1);
		repeat (delay) @(negedge clk);
		char_ack = 1'b0;
	endtask

	task automatic send_line(input string line);
		int i;
		exp_q.push_back(parse_line(line));
		sent++;
		for (i = 0; i < line.len(); i++) begin
			send_char(line[i]);
		end
		send_char(8'h0a);
	endtask

	task automatic finish_test(input string name);
		int t;
		t = 0;
		while (checked < sent && !hung) begin
			@(negedge clk);
			t++;
			if (t > WAIT_LIMIT) begin
				$display("timeout: test %s is still waiting for commands", name);
				hung = 1'b1;
				errors++;
			end
		end
		if (errors == err_mark) begin
			passed++;
			$display("test %s: pass", name);
		end else begin
			failed++;
			$display("test %s: fail with %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// command sink with a random acknowledge delay
	initial begin
		int delay;
		int t;
		cmd_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (cmd_req && !cmd_ack) begin
				got_q.push_back(cmd);
				delay = $urandom % (sink_max + 1);
				repeat (delay) @(negedge clk);
				cmd_ack = 1'b1;
				t = 0;
				while (cmd_req && !hung) begin
					@(negedge clk);
					t++;
					if (t > WAIT_LIMIT) begin
						$display("timeout: the DUT never released cmd_req");
						hung = 1'b1;
						errors++;
					end
				end
				delay = $urandom % (sink_max + 1);
				repeat (delay) @(negedge clk);
				cmd_ack = 1'b0;
			end
		end
	end

	// compares received commands with the reference in order
	initial begin
		gcode_cmd_t got;
		gcode_cmd_t exp;
		forever begin
			@(negedge clk);
			if (got_q.size() > 0) begin
				got = got_q.pop_front();
				if (exp_q.size() == 0) begin
					$display("the DUT produced a command that no line accounts for");
					errors++;
				end else begin
					exp = exp_q.pop_front();
					compare_cmd(got, exp);
				end
				checked++;
			end
		end
	end

	initial begin
		reset = 1'b1;
		char_ack = 1'b0;
		char_data = '0;
		sent = 0;
		checked = 0;
		errors = 0;
		err_mark = 0;
		passed = 0;
		failed = 0;
		src_max = 0;
		sink_max = 0;
		hung = 1'b0;
		void'($urandom(32'h809a));
		repeat (8) @(negedge clk);
		reset = 1'b0;
		send_line("G1 X10 Y-5");
		finish_test("basic");
		send_line("G1 X1.5 Z-0.25 F2.125");
		finish_test("fraction");
		send_line("G0 X200 Y-128");
		finish_test("range");
		send_line("G1 Q3");
		send_line("");
		send_line("G1 5");
		finish_test("error");
		src_max = 3;
		sink_max = 8;
		repeat (20) send_line(random_line());
		finish_test("random");
		$display("tests passed: %0d, tests failed: %0d", passed, failed);
		if (failed == 0 && errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== gcode_parser.f ====
+incdir+rtl
rtl/gcode_pkg.sv
rtl/char_decoder.sv
rtl/number_builder.sv
rtl/arg_subparser.sv
rtl/command_assembler.sv
rtl/gcode_parser.sv
sim/tb_gcode_parser.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -Wno-fatal \
	-f gcode_parser.f --top-module tb_gcode_parser -o tb_gcode_parser > "$LOG" 2>&1 &&
	./obj_dir/tb_gcode_parser >> "$LOG" 2>&1 ||
	echo "build or run returned an error" >> "$LOG"
cat "$LOG"
grep -q "Test failed" "$LOG" && { echo "simulation reported failure"; exit 1; }
grep -q "Test completed successfully" "$LOG" || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
exit 0
